//--- src/cnn_pkg.sv
package cnn_pkg;

//==========================================================
// widths and sizes
//==========================================================

  localparam int DWIDTH     = 16;
  localparam int ACC_WIDTH  = 40;
  localparam int LWIDTH     = 8;
  localparam int IMG_AWIDTH = 10;
  localparam int NET_AWIDTH = 8;
  localparam int KERN       = 3;
  localparam int WB_AWIDTH  = 12;

//==========================================================
// bus map
//==========================================================

  // bits 11..10 of the word address
  localparam logic [1:0] REGION_REG = 2'd0;
  localparam logic [1:0] REGION_NET = 2'd1;
  localparam logic [1:0] REGION_IMG = 2'd2;

  localparam logic [WB_AWIDTH-3:0] REG_CTRL       = 'd0;
  localparam logic [WB_AWIDTH-3:0] REG_QBITS      = 'd1;
  localparam logic [WB_AWIDTH-3:0] REG_TOTAL_IN   = 'd2;
  localparam logic [WB_AWIDTH-3:0] REG_TOTAL_OUT  = 'd3;
  localparam logic [WB_AWIDTH-3:0] REG_HEIGHT     = 'd4;
  localparam logic [WB_AWIDTH-3:0] REG_WIDTH      = 'd5;
  localparam logic [WB_AWIDTH-3:0] REG_IN_OFFSET  = 'd6;
  localparam logic [WB_AWIDTH-3:0] REG_OUT_OFFSET = 'd7;
  localparam logic [WB_AWIDTH-3:0] REG_NET_OFFSET = 'd8;
  // bit 0 relu, bit 1 bias
  localparam logic [WB_AWIDTH-3:0] REG_FLAGS      = 'd9;

  typedef enum logic [1:0] {
    S_WAIT, S_BIAS, S_CONV, S_DRAIN
  } ctrl_state_e;

endpackage

//--- src/cnn_mem.sv
module cnn_mem #(
  parameter int AWIDTH = 10
)
  ( input  logic                       clk
  , input  logic                       a_we
  , input  logic [AWIDTH-1:0]          a_addr
  , input  logic [cnn_pkg::DWIDTH-1:0] a_wdata
  , input  logic                       b_we
  , input  logic [AWIDTH-1:0]          b_addr
  , input  logic [cnn_pkg::DWIDTH-1:0] b_wdata
  , output logic [cnn_pkg::DWIDTH-1:0] a_rdata
  , output logic [cnn_pkg::DWIDTH-1:0] b_rdata
  );
  import cnn_pkg::*;

  logic [DWIDTH-1:0] ram [2**AWIDTH];

  // read returns the old word on a same-address write
  always @(posedge clk) begin
    if (a_we)
      ram[a_addr] <= a_wdata;
    a_rdata <= ram[a_addr];
  end

  always @(posedge clk) begin
    if (b_we)
      ram[b_addr] <= b_wdata;
    b_rdata <= ram[b_addr];
  end

endmodule

//--- src/cnn_wb_regs.sv
module cnn_wb_regs
  ( input  logic                           clk
  , input  logic                           xrst
  , input  logic                           wb_cyc
  , input  logic                           wb_stb
  , input  logic                           wb_we
  , input  logic [cnn_pkg::WB_AWIDTH-1:0]  wb_adr
  , input  logic [cnn_pkg::DWIDTH-1:0]     wb_dat_w
  , input  logic                           busy
  , input  logic [cnn_pkg::DWIDTH-1:0]     img_host_rdata
  , input  logic [cnn_pkg::DWIDTH-1:0]     net_host_rdata
  , output logic [cnn_pkg::DWIDTH-1:0]     wb_dat_r
  , output logic                           wb_ack
  , output logic                           img_host_we
  , output logic [cnn_pkg::IMG_AWIDTH-1:0] img_host_addr
  , output logic [cnn_pkg::DWIDTH-1:0]     img_host_wdata
  , output logic                           net_host_we
  , output logic [cnn_pkg::NET_AWIDTH-1:0] net_host_addr
  , output logic [cnn_pkg::DWIDTH-1:0]     net_host_wdata
  , output logic                           start
  , output logic [cnn_pkg::LWIDTH-1:0]     qbits
  , output logic [cnn_pkg::LWIDTH-1:0]     total_in
  , output logic [cnn_pkg::LWIDTH-1:0]     total_out
  , output logic [cnn_pkg::LWIDTH-1:0]     img_height
  , output logic [cnn_pkg::LWIDTH-1:0]     img_width
  , output logic [cnn_pkg::IMG_AWIDTH-1:0] in_offset
  , output logic [cnn_pkg::IMG_AWIDTH-1:0] out_offset
  , output logic [cnn_pkg::NET_AWIDTH-1:0] net_offset
  , output logic                           relu_en
  , output logic                           bias_en
  );
  import cnn_pkg::*;

  logic                 req;
  logic [1:0]           region;
  logic [WB_AWIDTH-3:0] idx;
  logic [1:0]           region_q;
  logic [DWIDTH-1:0]    reg_rdata;

  // a new request only while ack is low
  assign req    = wb_cyc && wb_stb && !wb_ack;
  assign region = wb_adr[WB_AWIDTH-1:WB_AWIDTH-2];
  assign idx    = wb_adr[WB_AWIDTH-3:0];

  assign img_host_we    = req && wb_we && region == REGION_IMG;
  assign img_host_addr  = idx[IMG_AWIDTH-1:0];
  assign img_host_wdata = wb_dat_w;
  assign net_host_we    = req && wb_we && region == REGION_NET;
  assign net_host_addr  = idx[NET_AWIDTH-1:0];
  assign net_host_wdata = wb_dat_w;

  always @(posedge clk)
    if (!xrst) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
    end
    else begin
      wb_ack <= req;
      start  <= req && wb_we && region == REGION_REG && idx == REG_CTRL && !busy;
    end

//==========================================================
// layer registers
//==========================================================

  always @(posedge clk)
    if (!xrst) begin
      qbits      <= '0;
      total_in   <= '0;
      total_out  <= '0;
      img_height <= '0;
      img_width  <= '0;
      in_offset  <= '0;
      out_offset <= '0;
      net_offset <= '0;
      relu_en    <= 1'b0;
      bias_en    <= 1'b0;
    end
    else if (req && wb_we && region == REGION_REG)
      case (idx)
        REG_QBITS:      qbits      <= wb_dat_w[LWIDTH-1:0];
        REG_TOTAL_IN:   total_in   <= wb_dat_w[LWIDTH-1:0];
        REG_TOTAL_OUT:  total_out  <= wb_dat_w[LWIDTH-1:0];
        REG_HEIGHT:     img_height <= wb_dat_w[LWIDTH-1:0];
        REG_WIDTH:      img_width  <= wb_dat_w[LWIDTH-1:0];
        REG_IN_OFFSET:  in_offset  <= wb_dat_w[IMG_AWIDTH-1:0];
        REG_OUT_OFFSET: out_offset <= wb_dat_w[IMG_AWIDTH-1:0];
        REG_NET_OFFSET: net_offset <= wb_dat_w[NET_AWIDTH-1:0];
        REG_FLAGS: begin
          relu_en <= wb_dat_w[0];
          bias_en <= wb_dat_w[1];
        end
        default: ;
      endcase

  // read side, region held for the ack cycle
  always @(posedge clk)
    if (req) begin
      region_q <= region;
      case (idx)
        REG_CTRL:       reg_rdata <= DWIDTH'(busy);
        REG_QBITS:      reg_rdata <= DWIDTH'(qbits);
        REG_TOTAL_IN:   reg_rdata <= DWIDTH'(total_in);
        REG_TOTAL_OUT:  reg_rdata <= DWIDTH'(total_out);
        REG_HEIGHT:     reg_rdata <= DWIDTH'(img_height);
        REG_WIDTH:      reg_rdata <= DWIDTH'(img_width);
        REG_IN_OFFSET:  reg_rdata <= DWIDTH'(in_offset);
        REG_OUT_OFFSET: reg_rdata <= DWIDTH'(out_offset);
        REG_NET_OFFSET: reg_rdata <= DWIDTH'(net_offset);
        REG_FLAGS:      reg_rdata <= DWIDTH'({bias_en, relu_en});
        default:        reg_rdata <= '0;
      endcase
    end

  always_comb
    case (region_q)
      REGION_REG: wb_dat_r = reg_rdata;
      REGION_NET: wb_dat_r = net_host_rdata;
      REGION_IMG: wb_dat_r = img_host_rdata;
      default:    wb_dat_r = '0;
    endcase

endmodule

//--- src/cnn_window_scan.sv
module cnn_window_scan
  ( input  logic                           clk
  , input  logic                           xrst
  , input  logic                           restart
  , input  logic                           step
  , input  logic [cnn_pkg::LWIDTH-1:0]     img_height
  , input  logic [cnn_pkg::LWIDTH-1:0]     img_width
  , input  logic [cnn_pkg::LWIDTH-1:0]     total_in
  , input  logic [cnn_pkg::IMG_AWIDTH-1:0] in_offset
  , output logic [cnn_pkg::IMG_AWIDTH-1:0] img_addr
  , output logic [cnn_pkg::NET_AWIDTH-1:0] weight_idx
  , output logic                           first
  , output logic                           last
  , output logic                           done
  );
  import cnn_pkg::*;

  logic [LWIDTH-1:0]     ox;
  logic [LWIDTH-1:0]     oy;
  logic [LWIDTH-1:0]     ci;
  logic [1:0]            kx;
  logic [1:0]            ky;
  logic [IMG_AWIDTH-1:0] plane;
  logic [IMG_AWIDTH-1:0] win_base;
  logic [IMG_AWIDTH-1:0] ch_base;
  logic [IMG_AWIDTH-1:0] row_base;
  logic [IMG_AWIDTH-1:0] win_next;
  logic                  kx_end;
  logic                  ky_end;
  logic                  ci_end;
  logic                  ox_end;
  logic                  oy_end;

  assign kx_end = kx == 2'(KERN - 1);
  assign ky_end = ky == 2'(KERN - 1);
  assign ci_end = ci == total_in - LWIDTH'(1);
  assign ox_end = ox == img_width - LWIDTH'(KERN);
  assign oy_end = oy == img_height - LWIDTH'(KERN);

  assign img_addr = row_base + IMG_AWIDTH'(kx);
  assign first    = kx == 2'd0 && ky == 2'd0 && ci == '0;
  assign last     = kx_end && ky_end && ci_end;

  // end of row jumps over the two border columns
  assign win_next = ox_end ? win_base + IMG_AWIDTH'(KERN) : win_base + IMG_AWIDTH'(1);

  always @(posedge clk)
    if (!xrst) begin
      ox         <= '0;
      oy         <= '0;
      ci         <= '0;
      kx         <= '0;
      ky         <= '0;
      weight_idx <= '0;
      done       <= 1'b0;
    end
    else if (restart) begin
      ox         <= '0;
      oy         <= '0;
      ci         <= '0;
      kx         <= '0;
      ky         <= '0;
      weight_idx <= '0;
      done       <= 1'b0;
    end
    else if (step && !done) begin
      weight_idx <= last ? '0 : weight_idx + NET_AWIDTH'(1);
      kx         <= kx_end ? 2'd0 : kx + 2'd1;
      if (kx_end) begin
        ky <= ky_end ? 2'd0 : ky + 2'd1;
        if (ky_end) begin
          ci <= ci_end ? '0 : ci + LWIDTH'(1);
          if (ci_end) begin
            ox <= ox_end ? '0 : ox + LWIDTH'(1);
            if (ox_end) begin
              if (oy_end)
                done <= 1'b1;
              else
                oy <= oy + LWIDTH'(1);
            end
          end
        end
      end
    end

//==========================================================
// incremental address bases
//==========================================================

  always @(posedge clk)
    if (restart) begin
      plane    <= IMG_AWIDTH'(img_height) * IMG_AWIDTH'(img_width);
      win_base <= in_offset;
      ch_base  <= in_offset;
      row_base <= in_offset;
    end
    else if (step && !done && kx_end)
      if (!ky_end)
        row_base <= row_base + IMG_AWIDTH'(img_width);
      else if (!ci_end) begin
        ch_base  <= ch_base + plane;
        row_base <= ch_base + plane;
      end
      else if (!(ox_end && oy_end)) begin
        win_base <= win_next;
        ch_base  <= win_next;
        row_base <= win_next;
      end

endmodule

//--- src/cnn_mac_unit.sv
module cnn_mac_unit
  ( input  logic                              clk
  , input  logic                              xrst
  , input  logic signed [cnn_pkg::DWIDTH-1:0] pix
  , input  logic signed [cnn_pkg::DWIDTH-1:0] weight
  , input  logic                              first
  , input  logic                              last
  , input  logic                              bias_load
  , input  logic signed [cnn_pkg::DWIDTH-1:0] bias
  , input  logic                              bias_en
  , input  logic                              relu_en
  , input  logic [cnn_pkg::LWIDTH-1:0]        qbits
  , output logic signed [cnn_pkg::DWIDTH-1:0] result
  , output logic                              result_valid
  );
  import cnn_pkg::*;

  logic signed [DWIDTH-1:0]    bias_r;
  logic signed [ACC_WIDTH-1:0] prod;
  logic signed [ACC_WIDTH-1:0] acc;
  logic signed [ACC_WIDTH-1:0] acc_next;
  logic signed [ACC_WIDTH-1:0] biased;
  logic signed [ACC_WIDTH-1:0] shifted;
  logic signed [DWIDTH-1:0]    sat;
  logic                        first_q;
  logic                        last_q;
  logic                        ovf;

  always @(posedge clk)
    if (bias_load)
      bias_r <= bias;

  // stage 1, product of the memory words
  always @(posedge clk)
    prod <= pix * weight;

  always @(posedge clk)
    if (!xrst) begin
      first_q      <= 1'b0;
      last_q       <= 1'b0;
      result_valid <= 1'b0;
    end
    else begin
      first_q      <= first;
      last_q       <= last;
      result_valid <= last_q;
    end

//==========================================================
// stage 2, accumulate and quantize
//==========================================================

  assign acc_next = first_q ? prod : acc + prod;
  assign biased   = bias_en ? acc_next + ACC_WIDTH'(bias_r) : acc_next;
  assign shifted  = biased >>> qbits;

  // upper bits must all copy the sign to fit 16 bits
  assign ovf = shifted[ACC_WIDTH-1:DWIDTH-1] != {(ACC_WIDTH-DWIDTH+1){shifted[ACC_WIDTH-1]}};

  always_comb
    if (!ovf)
      sat = shifted[DWIDTH-1:0];
    else if (shifted[ACC_WIDTH-1])
      sat = {1'b1, {(DWIDTH-1){1'b0}}};
    else
      sat = {1'b0, {(DWIDTH-1){1'b1}}};

  always @(posedge clk) begin
    acc    <= acc_next;
    result <= relu_en && sat[DWIDTH-1] ? '0 : sat;
  end

endmodule

//--- src/cnn_ctrl_core.sv
module cnn_ctrl_core
  ( input  logic                              clk
  , input  logic                              xrst
  , input  logic                              start
  , input  logic [cnn_pkg::LWIDTH-1:0]        qbits
  , input  logic [cnn_pkg::LWIDTH-1:0]        total_in
  , input  logic [cnn_pkg::LWIDTH-1:0]        total_out
  , input  logic [cnn_pkg::LWIDTH-1:0]        img_height
  , input  logic [cnn_pkg::LWIDTH-1:0]        img_width
  , input  logic [cnn_pkg::IMG_AWIDTH-1:0]    in_offset
  , input  logic [cnn_pkg::IMG_AWIDTH-1:0]    out_offset
  , input  logic [cnn_pkg::NET_AWIDTH-1:0]    net_offset
  , input  logic                              relu_en
  , input  logic                              bias_en
  , input  logic signed [cnn_pkg::DWIDTH-1:0] img_core_rdata
  , input  logic signed [cnn_pkg::DWIDTH-1:0] net_core_rdata
  , output logic                              busy
  , output logic                              img_core_we
  , output logic [cnn_pkg::IMG_AWIDTH-1:0]    img_core_addr
  , output logic signed [cnn_pkg::DWIDTH-1:0] img_core_wdata
  , output logic [cnn_pkg::NET_AWIDTH-1:0]    net_core_addr
  );
  import cnn_pkg::*;

  ctrl_state_e state;

  logic [LWIDTH-1:0]        qbits_r;
  logic [LWIDTH-1:0]        total_in_r;
  logic [LWIDTH-1:0]        total_out_r;
  logic [LWIDTH-1:0]        height_r;
  logic [LWIDTH-1:0]        width_r;
  logic [LWIDTH-1:0]        out_ch;
  logic [IMG_AWIDTH-1:0]    in_offset_r;
  logic [IMG_AWIDTH-1:0]    out_addr;
  logic [NET_AWIDTH-1:0]    net_base;
  logic [NET_AWIDTH-1:0]    blk_size;
  logic                     relu_en_r;
  logic                     bias_en_r;
  logic                     bias_rd;

  logic                     step;
  logic [IMG_AWIDTH-1:0]    scan_addr;
  logic [NET_AWIDTH-1:0]    weight_idx;
  logic                     scan_first;
  logic                     scan_last;
  logic                     scan_done;
  logic                     rd_valid;
  logic                     first_d;
  logic                     last_d;
  logic signed [DWIDTH-1:0] pix;
  logic signed [DWIDTH-1:0] result;
  logic                     result_valid;

//==========================================================
// layer FSM
//==========================================================

  assign busy = state != S_WAIT;

  // a result write steals the image port for one cycle
  assign step           = state == S_CONV && !scan_done && !result_valid;
  assign img_core_we    = result_valid;
  assign img_core_addr  = result_valid ? out_addr : scan_addr;
  assign img_core_wdata = result;
  assign net_core_addr  = state == S_BIAS ? net_base
                                          : net_base + weight_idx + NET_AWIDTH'(1);

  always @(posedge clk)
    if (!xrst) begin
      state   <= S_WAIT;
      out_ch  <= '0;
      bias_rd <= 1'b0;
    end
    else
      case (state)
        S_WAIT:
          if (start) begin
            state  <= S_BIAS;
            out_ch <= '0;
          end
        S_BIAS: begin
          bias_rd <= !bias_rd;
          if (bias_rd)
            state <= S_CONV;
        end
        S_CONV:
          if (scan_done)
            state <= S_DRAIN;
        // a window is longer than the pipe, so the first write here is the last one
        S_DRAIN:
          if (result_valid)
            if (out_ch == total_out_r - LWIDTH'(1))
              state <= S_WAIT;
            else begin
              state  <= S_BIAS;
              out_ch <= out_ch + LWIDTH'(1);
            end
        default:
          state <= S_WAIT;
      endcase

  always @(posedge clk)
    if (state == S_WAIT && start) begin
      qbits_r     <= qbits;
      total_in_r  <= total_in;
      total_out_r <= total_out;
      height_r    <= img_height;
      width_r     <= img_width;
      in_offset_r <= in_offset;
      relu_en_r   <= relu_en;
      bias_en_r   <= bias_en;
      out_addr    <= out_offset;
      net_base    <= net_offset;
      blk_size    <= NET_AWIDTH'(total_in) * NET_AWIDTH'(KERN * KERN) + NET_AWIDTH'(1);
    end
    else if (result_valid) begin
      out_addr <= out_addr + IMG_AWIDTH'(1);
      if (state == S_DRAIN)
        net_base <= net_base + blk_size;
    end

  // marks follow the read latency
  always @(posedge clk)
    if (!xrst) begin
      rd_valid <= 1'b0;
      first_d  <= 1'b0;
      last_d   <= 1'b0;
    end
    else begin
      rd_valid <= step;
      first_d  <= step && scan_first;
      last_d   <= step && scan_last;
    end

  assign pix = rd_valid ? img_core_rdata : '0;

  cnn_window_scan i_scan
    ( .clk        (clk)
    , .xrst       (xrst)
    , .restart    (state == S_BIAS)
    , .step       (step)
    , .img_height (height_r)
    , .img_width  (width_r)
    , .total_in   (total_in_r)
    , .in_offset  (in_offset_r)
    , .img_addr   (scan_addr)
    , .weight_idx (weight_idx)
    , .first      (scan_first)
    , .last       (scan_last)
    , .done       (scan_done)
    );

  cnn_mac_unit i_mac
    ( .clk          (clk)
    , .xrst         (xrst)
    , .pix          (pix)
    , .weight       (net_core_rdata)
    , .first        (first_d)
    , .last         (last_d)
    , .bias_load    (state == S_BIAS && bias_rd)
    , .bias         (net_core_rdata)
    , .bias_en      (bias_en_r)
    , .relu_en      (relu_en_r)
    , .qbits        (qbits_r)
    , .result       (result)
    , .result_valid (result_valid)
    );

endmodule

//--- src/cnn_top.sv
module cnn_top
  ( input  logic                          clk
  , input  logic                          xrst
  , input  logic                          wb_cyc
  , input  logic                          wb_stb
  , input  logic                          wb_we
  , input  logic [cnn_pkg::WB_AWIDTH-1:0] wb_adr
  , input  logic [cnn_pkg::DWIDTH-1:0]    wb_dat_w
  , output logic [cnn_pkg::DWIDTH-1:0]    wb_dat_r
  , output logic                          wb_ack
  , output logic                          busy
  );
  import cnn_pkg::*;

  logic                  img_host_we;
  logic [IMG_AWIDTH-1:0] img_host_addr;
  logic [DWIDTH-1:0]     img_host_wdata;
  logic [DWIDTH-1:0]     img_host_rdata;
  logic                  net_host_we;
  logic [NET_AWIDTH-1:0] net_host_addr;
  logic [DWIDTH-1:0]     net_host_wdata;
  logic [DWIDTH-1:0]     net_host_rdata;
  logic                  img_core_we;
  logic [IMG_AWIDTH-1:0] img_core_addr;
  logic [DWIDTH-1:0]     img_core_wdata;
  logic [DWIDTH-1:0]     img_core_rdata;
  logic [NET_AWIDTH-1:0] net_core_addr;
  logic [DWIDTH-1:0]     net_core_rdata;

  logic                  start;
  logic [LWIDTH-1:0]     qbits;
  logic [LWIDTH-1:0]     total_in;
  logic [LWIDTH-1:0]     total_out;
  logic [LWIDTH-1:0]     img_height;
  logic [LWIDTH-1:0]     img_width;
  logic [IMG_AWIDTH-1:0] in_offset;
  logic [IMG_AWIDTH-1:0] out_offset;
  logic [NET_AWIDTH-1:0] net_offset;
  logic                  relu_en;
  logic                  bias_en;

  cnn_wb_regs i_regs (.*);

  cnn_ctrl_core i_core (.*);

  // feature maps, input and output
  cnn_mem #(.AWIDTH(IMG_AWIDTH)) i_img_mem
    ( .clk     (clk)
    , .a_we    (img_host_we)
    , .a_addr  (img_host_addr)
    , .a_wdata (img_host_wdata)
    , .b_we    (img_core_we)
    , .b_addr  (img_core_addr)
    , .b_wdata (img_core_wdata)
    , .a_rdata (img_host_rdata)
    , .b_rdata (img_core_rdata)
    );

  // weights and biases, read only from the core side
  cnn_mem #(.AWIDTH(NET_AWIDTH)) i_net_mem
    ( .clk     (clk)
    , .a_we    (net_host_we)
    , .a_addr  (net_host_addr)
    , .a_wdata (net_host_wdata)
    , .b_we    (1'b0)
    , .b_addr  (net_core_addr)
    , .b_wdata ('0)
    , .a_rdata (net_host_rdata)
    , .b_rdata (net_core_rdata)
    );

endmodule

//--- tb/cnn_assert.sv
module cnn_assert
  ( input logic                             clk
  , input logic                             xrst
  , input logic                             busy
  , input logic                             step
  , input logic                             img_core_we
  , input logic [cnn_pkg::IMG_AWIDTH-1:0]   scan_addr
  , input cnn_pkg::ctrl_state_e             state
  );
  timeunit 1ns;
  timeprecision 1ps;
  import cnn_pkg::*;

  // a result write takes the image port away from the scan, the scan address holds
  a_write_not_step: assert property (@(posedge clk) disable iff (!xrst)
    img_core_we |=> $stable(scan_addr))
    else $error("scan moved on during an image write");

  // nothing moves on the image port while idle
  a_idle_no_step: assert property (@(posedge clk) disable iff (!xrst)
    !busy |-> !step && !img_core_we)
    else $error("scan step or image write while the core is idle");

  // busy ends one clock after the last write of the drain state
  a_end_in_wait: assert property (@(posedge clk) disable iff (!xrst)
    $fell(busy) |-> state == S_WAIT && $past(state) == S_DRAIN && $past(img_core_we))
    else $error("busy fell without a final write in the drain state");

endmodule

bind cnn_ctrl_core cnn_assert i_assert
  ( .clk         (clk)
  , .xrst        (xrst)
  , .busy        (busy)
  , .step        (step)
  , .img_core_we (img_core_we)
  , .scan_addr   (scan_addr)
  , .state       (state)
  );

//--- tb/tb_cnn_top.sv
module tb_cnn_top;
  timeunit 1ns;
  timeprecision 1ps;
  import cnn_pkg::*;

  localparam int ACK_TIMEOUT  = 16;
  localparam int BUSY_TIMEOUT = 20000;

  logic                 clk;
  logic                 xrst;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [WB_AWIDTH-1:0] wb_adr;
  logic [DWIDTH-1:0]    wb_dat_w;
  logic [DWIDTH-1:0]    wb_dat_r;
  logic                 wb_ack;
  logic                 busy;

  int seed = 99004;

  // shadow copies of both memories
  logic [DWIDTH-1:0] img_model [2**IMG_AWIDTH];
  logic [DWIDTH-1:0] net_model [2**NET_AWIDTH];

  int h;
  int w;
  int tin;
  int tout;
  int qb;
  int in_off;
  int out_off;
  int net_off;
  bit relu_on;
  bit bias_on;

  cnn_top i_dut (.*);

  always #50 clk = ~clk;

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return lo + r % (hi - lo + 1);
  endfunction

  function automatic logic [WB_AWIDTH-1:0] adr_of(input logic [1:0] region,
                                                   input logic [WB_AWIDTH-3:0] idx);
    return {region, idx};
  endfunction

  // bits that each register keeps
  function automatic logic [DWIDTH-1:0] reg_mask(input logic [WB_AWIDTH-3:0] idx);
    case (idx)
      REG_IN_OFFSET:  return 16'h03ff;
      REG_OUT_OFFSET: return 16'h03ff;
      REG_NET_OFFSET: return 16'h00ff;
      REG_FLAGS:      return 16'h0003;
      default:        return 16'h00ff;
    endcase
  endfunction

//==========================================================
// reference model
//==========================================================

  function automatic logic [DWIDTH-1:0] ref_pixel(input int o, input int y, input int x);
    longint acc;
    int     blk;
    int     pa;
    blk = net_off + o * (tin * KERN * KERN + 1);
    acc = 0;
    for (int ci = 0; ci < tin; ci++)
      for (int ky = 0; ky < KERN; ky++)
        for (int kx = 0; kx < KERN; kx++) begin
          pa  = in_off + ci * h * w + (y + ky) * w + x + kx;
          acc += longint'($signed(img_model[pa]))
               * longint'($signed(net_model[blk + 1 + ci * 9 + ky * 3 + kx]));
        end
    if (bias_on)
      acc += longint'($signed(net_model[blk]));
    acc = acc >>> qb;
    if (acc > 32767)
      acc = 32767;
    else if (acc < -32768)
      acc = -32768;
    if (relu_on && acc < 0)
      acc = 0;
    return DWIDTH'(acc);
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input int index,
                             input logic [DWIDTH-1:0] exp, input logic [DWIDTH-1:0] got);
    assert (got === exp) else
      abort_run($sformatf("FAILED %s[%0d] expected 0x%h got 0x%h", name, index, exp, got));
  endtask

//==========================================================
// wishbone master
//==========================================================

  task automatic wb_cycle(input logic we, input logic [WB_AWIDTH-1:0] adr,
                          input logic [DWIDTH-1:0] wdata, output logic [DWIDTH-1:0] rdata);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    n = 0;
    @(negedge clk);
    while (!wb_ack && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (wb_ack) else abort_run($sformatf("no Wishbone ack for address 0x%h", adr));
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    assert (!wb_ack) else abort_run("Wishbone ack lasted more than one cycle");
  endtask

  task automatic wb_write(input logic [WB_AWIDTH-1:0] adr, input logic [DWIDTH-1:0] data);
    logic [DWIDTH-1:0] unused;
    wb_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wait_busy_low();
    int n;
    n = 0;
    while (busy && n < BUSY_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (!busy) else abort_run("timeout while waiting for busy to fall");
  endtask

  task automatic check_registers();
    logic [DWIDTH-1:0]    written [10];
    logic [DWIDTH-1:0]    d;
    logic [WB_AWIDTH-3:0] idx;
    wb_cycle(1'b0, adr_of(REGION_REG, REG_CTRL), '0, d);
    check_value("wb_dat_r", 0, 16'h0000, d);
    for (int i = 1; i <= int'(REG_FLAGS); i++) begin
      idx        = (WB_AWIDTH-2)'(i);
      written[i] = DWIDTH'(rand_range(0, 65535));
      wb_write(adr_of(REGION_REG, idx), written[i]);
    end
    for (int i = 1; i <= int'(REG_FLAGS); i++) begin
      idx = (WB_AWIDTH-2)'(i);
      wb_cycle(1'b0, adr_of(REGION_REG, idx), '0, d);
      check_value("wb_dat_r", i, written[i] & reg_mask(idx), d);
    end
  endtask

  task automatic fill_image();
    for (int a = 0; a < 2**IMG_AWIDTH; a++) begin
      img_model[a] = DWIDTH'(a * 40503) ^ 16'h5a5a;
      wb_write(adr_of(REGION_IMG, (WB_AWIDTH-2)'(a)), img_model[a]);
    end
  endtask

  // mode 0 plain single channel, 1 bias and relu, 2 random flags
  task automatic run_layer(input int mode, input bit extra_start);
    int                vlim;
    int                n_out;
    int                out_end;
    logic [DWIDTH-1:0] d;
    h = rand_range(3, 8);
    w = rand_range(3, 8);
    if (mode == 0) begin
      tin     = 1;
      tout    = 1;
      qb      = 0;
      bias_on = 1'b0;
      relu_on = 1'b0;
      vlim    = 7;
    end
    else begin
      tin     = rand_range(1, 3);
      tout    = rand_range(1, 3);
      qb      = rand_range(0, 6);
      bias_on = mode == 1 || rand_range(0, 1) == 1;
      relu_on = mode == 1 || rand_range(0, 1) == 1;
      vlim    = 127;
    end
    in_off  = rand_range(0, 300);
    out_off = in_off + tin * h * w + rand_range(1, 100);
    net_off = rand_range(0, 100);
    n_out   = (h - 2) * (w - 2);
    for (int a = 0; a < tin * h * w; a++) begin
      img_model[in_off + a] = DWIDTH'(rand_range(-vlim, vlim));
      wb_write(adr_of(REGION_IMG, (WB_AWIDTH-2)'(in_off + a)), img_model[in_off + a]);
    end
    for (int a = 0; a < tout * (tin * KERN * KERN + 1); a++) begin
      net_model[net_off + a] = DWIDTH'(rand_range(-vlim, vlim));
      wb_write(adr_of(REGION_NET, (WB_AWIDTH-2)'(net_off + a)), net_model[net_off + a]);
    end
    wb_write(adr_of(REGION_REG, REG_QBITS), DWIDTH'(qb));
    wb_write(adr_of(REGION_REG, REG_TOTAL_IN), DWIDTH'(tin));
    wb_write(adr_of(REGION_REG, REG_TOTAL_OUT), DWIDTH'(tout));
    wb_write(adr_of(REGION_REG, REG_HEIGHT), DWIDTH'(h));
    wb_write(adr_of(REGION_REG, REG_WIDTH), DWIDTH'(w));
    wb_write(adr_of(REGION_REG, REG_IN_OFFSET), DWIDTH'(in_off));
    wb_write(adr_of(REGION_REG, REG_OUT_OFFSET), DWIDTH'(out_off));
    wb_write(adr_of(REGION_REG, REG_NET_OFFSET), DWIDTH'(net_off));
    wb_write(adr_of(REGION_REG, REG_FLAGS), DWIDTH'({bias_on, relu_on}));
    wb_write(adr_of(REGION_REG, REG_CTRL), 16'h0001);
    assert (busy) else abort_run("busy did not rise after the start write");
    // second start lands while busy
    if (extra_start)
      wb_write(adr_of(REGION_REG, REG_CTRL), 16'h0001);
    wait_busy_low();
    repeat (8) begin
      @(negedge clk);
      assert (!busy) else abort_run("busy rose again without a start");
    end
    for (int o = 0; o < tout; o++)
      for (int y = 0; y < h - 2; y++)
        for (int x = 0; x < w - 2; x++)
          img_model[out_off + o * n_out + y * (w - 2) + x] = ref_pixel(o, y, x);
    // input, gap, outputs and a few words past the end
    out_end = out_off + tout * n_out;
    for (int a = in_off; a < out_end + 3; a++) begin
      wb_cycle(1'b0, adr_of(REGION_IMG, (WB_AWIDTH-2)'(a)), '0, d);
      check_value("img_mem", a, img_model[a], d);
    end
    wb_cycle(1'b0, adr_of(REGION_REG, REG_CTRL), '0, d);
    check_value("wb_dat_r", 0, 16'h0000, d);
  endtask

  initial begin
    clk      = 1'b0;
    xrst     = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (3) @(negedge clk);
    xrst = 1'b1;
    @(negedge clk);
    check_registers();
    fill_image();
    run_layer(0, 1'b0);
    run_layer(1, 1'b0);
    run_layer(1, 1'b0);
    for (int r = 0; r < 3; r++)
      run_layer(2, 1'b1);
    $display("Everything OK");
    $finish;
  end

endmodule

//--- filelist.f
src/cnn_pkg.sv
src/cnn_mem.sv
src/cnn_wb_regs.sv
src/cnn_window_scan.sv
src/cnn_mac_unit.sv
src/cnn_ctrl_core.sv
src/cnn_top.sv
tb/cnn_assert.sv
tb/tb_cnn_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_cnn_top
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation reported an error"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
